//--- lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

////////////////////////////////////////
// Load/store path dimensions
////////////////////////////////////////

// Width of one data word on the bus
`define LSU_DATA_W 32

// Byte lanes per data word
`define LSU_BE_W 4

// Full byte address width
`define LSU_ADDR_W 32

// Bits of the address that select a lane
`define LSU_OFFSET_W 2

`endif

//--- logic/lsu_pkg.sv
`default_nettype none

`include "lsu_config.svh"

package lsu_pkg;

  ////////////////////////////////////////
  // Access size
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  ////////////////////////////////////////
  // Command from the execute stage
  ////////////////////////////////////////

  typedef struct packed {
    logic                   we;
    lsu_size_e              size;
    logic                   sign_ext;
    logic [`LSU_ADDR_W-1:0] addr;
    // Store data, still in the low lanes
    logic [`LSU_DATA_W-1:0] wdata;
  } lsu_cmd_t;

  // Request as seen on the data bus
  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;
    logic                   we;
    logic [`LSU_BE_W-1:0]   be;
    logic [`LSU_DATA_W-1:0] wdata;
  } lsu_bus_req_t;

  // Result returned with resp_valid_o
  typedef struct packed {
    logic [`LSU_DATA_W-1:0] rdata;
    logic                   load_err;
    logic                   store_err;
    logic                   misaligned;
  } lsu_resp_t;

endpackage

`default_nettype wire

//--- logic/lsu_align.sv
`default_nettype none

`include "lsu_config.svh"

module lsu_align (
  input  lsu_pkg::lsu_cmd_t     cmd_i,
  output lsu_pkg::lsu_bus_req_t bus_o,
  output logic                  misaligned_o
);

  logic [`LSU_OFFSET_W-1:0] offset;
  logic [`LSU_BE_W-1:0]     be;
  logic                     misaligned;

  assign offset = cmd_i.addr[`LSU_OFFSET_W-1:0];

  ////////////////////////////////////////
  // Byte enables and alignment
  ////////////////////////////////////////

  always_comb begin
    be         = '0;
    misaligned = 1'b0;
    case (cmd_i.size)
      lsu_pkg::SIZE_BYTE: begin
        be = `LSU_BE_W'(4'b0001 << offset);
      end
      lsu_pkg::SIZE_HALF: begin
        be         = `LSU_BE_W'(4'b0011 << offset);
        // Only even offsets keep both lanes in one word
        misaligned = offset[0];
      end
      lsu_pkg::SIZE_WORD: begin
        be         = '1;
        misaligned = (offset != '0);
      end
      default: begin
        // Unused size code, handled like a word
        be         = '1;
        misaligned = (offset != '0);
      end
    endcase
  end

  ////////////////////////////////////////
  // Bus request
  ////////////////////////////////////////

  always_comb begin
    bus_o.addr  = {cmd_i.addr[`LSU_ADDR_W-1:`LSU_OFFSET_W], {`LSU_OFFSET_W{1'b0}}};
    bus_o.we    = cmd_i.we;
    bus_o.be    = be;
    // Move store data up to its first lane
    bus_o.wdata = cmd_i.wdata << {offset, 3'b000};
  end

  assign misaligned_o = misaligned;

endmodule

`default_nettype wire

//--- logic/lsu_load_extract.sv
`default_nettype none

`include "lsu_config.svh"

module lsu_load_extract (
  input  logic [`LSU_DATA_W-1:0]   rdata_i,
  input  logic [`LSU_OFFSET_W-1:0] offset_i,
  input  lsu_pkg::lsu_size_e       size_i,
  input  logic                     sign_ext_i,
  output logic [`LSU_DATA_W-1:0]   data_o
);

  logic [`LSU_DATA_W-1:0] shifted;
  logic                   byte_msb;
  logic                   half_msb;

  // Bring the addressed lane down to bit 0
  assign shifted = rdata_i >> {offset_i, 3'b000};

  // Fill bits, zero unless a signed load
  assign byte_msb = sign_ext_i & shifted[7];
  assign half_msb = sign_ext_i & shifted[15];

  ////////////////////////////////////////
  // Size selection and extension
  ////////////////////////////////////////

  always_comb begin
    case (size_i)
      lsu_pkg::SIZE_BYTE: begin
        data_o = {{(`LSU_DATA_W-8){byte_msb}}, shifted[7:0]};
      end
      lsu_pkg::SIZE_HALF: begin
        data_o = {{(`LSU_DATA_W-16){half_msb}}, shifted[15:0]};
      end
      lsu_pkg::SIZE_WORD: begin
        data_o = shifted;
      end
      default: begin
        data_o = shifted;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/lsu_bus_fsm.sv
`default_nettype none

`include "lsu_config.svh"

module lsu_bus_fsm (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Command attributes
  input  logic                     cmd_valid_i,
  input  logic                     cmd_we_i,
  input  lsu_pkg::lsu_size_e       cmd_size_i,
  input  logic                     cmd_sign_ext_i,
  input  logic [`LSU_OFFSET_W-1:0] cmd_offset_i,
  input  lsu_pkg::lsu_bus_req_t    align_bus_i,
  input  logic                     misaligned_i,
  output logic                     busy_o,
  // Data bus
  output logic                     data_req_o,
  output lsu_pkg::lsu_bus_req_t    data_bus_o,
  input  logic                     data_gnt_i,
  input  logic                     data_rvalid_i,
  input  logic                     data_err_i,
  input  logic [`LSU_DATA_W-1:0]   data_rdata_i,
  // Load extraction
  input  logic [`LSU_DATA_W-1:0]   ext_data_i,
  output lsu_pkg::lsu_size_e       ext_size_o,
  output logic                     ext_sign_ext_o,
  output logic [`LSU_OFFSET_W-1:0] ext_offset_o,
  // Response
  output logic                     resp_valid_o,
  output lsu_pkg::lsu_resp_t       resp_o
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_RVALID
  } state_e;

  state_e                   state_q;
  state_e                   state_d;
  logic                     accept;
  logic                     resp_load;
  logic                     resp_valid_q;
  lsu_pkg::lsu_resp_t       resp_d;
  lsu_pkg::lsu_resp_t       resp_q;
  lsu_pkg::lsu_bus_req_t    bus_q;
  logic                     we_q;
  lsu_pkg::lsu_size_e       size_q;
  logic                     sign_ext_q;
  logic [`LSU_OFFSET_W-1:0] offset_q;

  // Busy also covers the cycle of the response pulse
  assign busy_o = (state_q != IDLE) | resp_valid_q;
  assign accept = cmd_valid_i & ~busy_o;

  ////////////////////////////////////////
  // Next state and response
  ////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    resp_load = 1'b0;
    resp_d    = '0;
    case (state_q)
      IDLE: begin
        if (accept) begin
          if (misaligned_i) begin
            // Refused without touching the bus
            resp_load         = 1'b1;
            resp_d.misaligned = 1'b1;
          end else begin
            state_d = REQ;
          end
        end
      end
      REQ: begin
        if (data_gnt_i) begin
          state_d = WAIT_RVALID;
        end
      end
      WAIT_RVALID: begin
        if (data_rvalid_i) begin
          state_d          = IDLE;
          resp_load        = 1'b1;
          resp_d.load_err  = data_err_i & ~we_q;
          resp_d.store_err = data_err_i & we_q;
          if (!we_q && !data_err_i) begin
            resp_d.rdata = ext_data_i;
          end
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      resp_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      resp_valid_q <= resp_load;
    end
  end

  // Access held for the whole bus transfer
  always_ff @(posedge clk_i) begin
    if (accept) begin
      bus_q      <= align_bus_i;
      we_q       <= cmd_we_i;
      size_q     <= cmd_size_i;
      sign_ext_q <= cmd_sign_ext_i;
      offset_q   <= cmd_offset_i;
    end
    if (resp_load) begin
      resp_q <= resp_d;
    end
  end

  assign data_req_o = (state_q == REQ);
  assign data_bus_o = bus_q;

  // Read data goes out raw and comes back extended
  assign ext_size_o     = size_q;
  assign ext_sign_ext_o = sign_ext_q;
  assign ext_offset_o   = offset_q;

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule

`default_nettype wire

//--- logic/lsu_top.sv
`default_nettype none

`include "lsu_config.svh"

module lsu_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Command from the execute stage
  input  logic                   cmd_valid_i,
  input  lsu_pkg::lsu_cmd_t      cmd_i,
  output logic                   busy_o,
  // Response
  output logic                   resp_valid_o,
  output lsu_pkg::lsu_resp_t     resp_o,
  // Data bus
  output logic                   data_req_o,
  output lsu_pkg::lsu_bus_req_t  data_bus_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  input  logic                   data_err_i
);

  lsu_pkg::lsu_bus_req_t    align_bus;
  logic                     misaligned;
  logic [`LSU_DATA_W-1:0]   ext_data;
  lsu_pkg::lsu_size_e       ext_size;
  logic                     ext_sign_ext;
  logic [`LSU_OFFSET_W-1:0] ext_offset;

  ////////////////////////////////////////
  // Alignment and lane steering
  ////////////////////////////////////////

  lsu_align u_align (
    .cmd_i        ( cmd_i      ),
    .bus_o        ( align_bus  ),
    .misaligned_o ( misaligned )
  );

  ////////////////////////////////////////
  // Bus protocol
  ////////////////////////////////////////

  lsu_bus_fsm u_bus_fsm (
    .clk_i          ( clk_i                          ),
    .rst_ni         ( rst_ni                         ),
    .cmd_valid_i    ( cmd_valid_i                    ),
    .cmd_we_i       ( cmd_i.we                       ),
    .cmd_size_i     ( cmd_i.size                     ),
    .cmd_sign_ext_i ( cmd_i.sign_ext                 ),
    .cmd_offset_i   ( cmd_i.addr[`LSU_OFFSET_W-1:0]  ),
    .align_bus_i    ( align_bus                      ),
    .misaligned_i   ( misaligned                     ),
    .busy_o         ( busy_o                         ),
    .data_req_o     ( data_req_o                     ),
    .data_bus_o     ( data_bus_o                     ),
    .data_gnt_i     ( data_gnt_i                     ),
    .data_rvalid_i  ( data_rvalid_i                  ),
    .data_err_i     ( data_err_i                     ),
    .data_rdata_i   ( data_rdata_i                   ),
    .ext_data_i     ( ext_data                       ),
    .ext_size_o     ( ext_size                       ),
    .ext_sign_ext_o ( ext_sign_ext                   ),
    .ext_offset_o   ( ext_offset                     ),
    .resp_valid_o   ( resp_valid_o                   ),
    .resp_o         ( resp_o                         )
  );

  // Load data extraction
  lsu_load_extract u_load_extract (
    .rdata_i    ( data_rdata_i ),
    .offset_i   ( ext_offset   ),
    .size_i     ( ext_size     ),
    .sign_ext_i ( ext_sign_ext ),
    .data_o     ( ext_data     )
  );

endmodule

`default_nettype wire

//--- bench/lsu_tb.sv
`default_nettype none

`include "lsu_config.svh"

module lsu_tb;

  localparam int CLK_PERIOD     = 8;
  localparam int NUM_CMDS       = 300;
  localparam int CYCLES_PER_CMD = 12;
  localparam int NUM_RANDOM     = 220;
  localparam int MEM_WORDS      = 64;
  localparam int ERR_BASE       = 60;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      cmd_valid_i;
  lsu_pkg::lsu_cmd_t         cmd_i;
  logic                      busy_o;
  logic                      resp_valid_o;
  lsu_pkg::lsu_resp_t        resp_o;
  logic                      data_req_o;
  lsu_pkg::lsu_bus_req_t     data_bus_o;
  logic                      data_gnt_i;
  logic                      data_rvalid_i;
  logic [`LSU_DATA_W-1:0]    data_rdata_i;
  logic                      data_err_i;

  logic [`LSU_DATA_W-1:0]    mem [MEM_WORDS];
  logic [`LSU_DATA_W-1:0]    shadow [MEM_WORDS];
  logic [31:0]               rng_state = 32'd12722;
  lsu_pkg::lsu_resp_t        exp_q [$];
  lsu_pkg::lsu_bus_req_t     exp_bus_q [$];
  lsu_pkg::lsu_resp_t        exp_resp;
  int                        errors;
  int                        cmd_count;
  int                        resp_count;
  int                        bus_count;
  int                        ignored_count;

  lsu_top u_lsu_top (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .cmd_valid_i   ( cmd_valid_i   ),
    .cmd_i         ( cmd_i         ),
    .busy_o        ( busy_o        ),
    .resp_valid_o  ( resp_valid_o  ),
    .resp_o        ( resp_o        ),
    .data_req_o    ( data_req_o    ),
    .data_bus_o    ( data_bus_o    ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_rdata_i  ( data_rdata_i  ),
    .data_err_i    ( data_err_i    )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("FAIL %0t %s: got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  function automatic lsu_pkg::lsu_cmd_t build_cmd(input logic we, input lsu_pkg::lsu_size_e size,
                                                  input logic sign_ext, input logic [31:0] addr,
                                                  input logic [31:0] wdata);
    lsu_pkg::lsu_cmd_t c;
    c.we       = we;
    c.size     = size;
    c.sign_ext = sign_ext;
    c.addr     = addr;
    c.wdata    = wdata;
    return c;
  endfunction

  function automatic lsu_pkg::lsu_cmd_t random_cmd();
    logic [31:0]        r;
    lsu_pkg::lsu_size_e size;
    logic [31:0]        addr;
    r = next_rand();
    case (r[2:1])
      2'd0:    size = lsu_pkg::SIZE_BYTE;
      2'd1:    size = lsu_pkg::SIZE_HALF;
      default: size = lsu_pkg::SIZE_WORD;
    endcase
    addr = {24'b0, r[15:8]};
    // Mostly aligned, so that the bus sees real traffic
    if (r[4] || r[5]) begin
      if (size == lsu_pkg::SIZE_HALF) addr[0] = 1'b0;
      if (size == lsu_pkg::SIZE_WORD) addr[1:0] = 2'b00;
    end
    return build_cmd(r[0], size, r[3], addr, next_rand());
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Expected response; also queues the expected bus request and updates shadow
  function automatic lsu_pkg::lsu_resp_t expect_resp(input lsu_pkg::lsu_cmd_t cmd);
    lsu_pkg::lsu_resp_t    r;
    lsu_pkg::lsu_bus_req_t b;
    int                    offset;
    int                    nbytes;
    int                    idx;
    logic [31:0]           word;
    r      = '0;
    offset = int'(cmd.addr[1:0]);
    idx    = int'(cmd.addr[7:2]);
    case (cmd.size)
      lsu_pkg::SIZE_BYTE: nbytes = 1;
      lsu_pkg::SIZE_HALF: nbytes = 2;
      default:            nbytes = 4;
    endcase
    if (offset % nbytes != 0) begin
      r.misaligned = 1'b1;
      return r;
    end
    b.addr  = {cmd.addr[31:2], 2'b00};
    b.we    = cmd.we;
    b.wdata = cmd.wdata << (8 * offset);
    for (int l = 0; l < 4; l++) begin
      b.be[l] = (l >= offset) && (l < offset + nbytes);
    end
    exp_bus_q.push_back(b);
    if (idx >= ERR_BASE) begin
      r.store_err = cmd.we;
      r.load_err  = !cmd.we;
      return r;
    end
    if (cmd.we) begin
      for (int l = offset; l < offset + nbytes; l++) begin
        shadow[idx][8*l +: 8] = cmd.wdata[8*(l-offset) +: 8];
      end
    end else begin
      word = shadow[idx] >> (8 * offset);
      for (int bit_i = 8 * nbytes; bit_i < 32; bit_i++) begin
        word[bit_i] = cmd.sign_ext ? word[8*nbytes-1] : 1'b0;
      end
      r.rdata = word;
    end
    return r;
  endfunction

  // Waits for idle, strobing junk while the LSU is busy, then issues cmd
  task automatic send_cmd(input lsu_pkg::lsu_cmd_t cmd);
    logic              stays_busy;
    logic              junk_go;
    lsu_pkg::lsu_cmd_t junk;
    @(negedge clk_i);
    while (busy_o) begin
      // Busy without a response now means busy in the next cycle too
      stays_busy = !resp_valid_o;
      junk       = random_cmd();
      junk_go    = stays_busy && (next_rand() % 3 == 0);
      @(posedge clk_i);
      cmd_valid_i <= junk_go;
      if (junk_go) begin
        cmd_i <= junk;
        ignored_count++;
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_i       <= cmd;
    exp_q.push_back(expect_resp(cmd));
    cmd_count++;
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
  endtask

  ////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////

  initial begin : memory_model
    lsu_pkg::lsu_bus_req_t req;
    int                    gnt_wait;
    int                    rv_wait;
    int                    idx;
    logic                  hit_err;
    logic [31:0]           rd;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    data_err_i    = 1'b0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && data_req_o) begin
        req = data_bus_o;
        if (exp_bus_q.size() == 0) begin
          errors++;
          $display("Bus request at %0t with no aligned command waiting for it", $time);
        end else begin
          check_value("data_bus_o", req, exp_bus_q.pop_front());
        end
        gnt_wait = next_rand() % 4;
        repeat (gnt_wait) begin
          @(negedge clk_i);
          check_value("data_req_o", data_req_o, 1'b1);
          check_value("data_bus_o", data_bus_o, req);
        end
        @(posedge clk_i);
        data_gnt_i <= 1'b1;
        idx     = int'(req.addr[7:2]);
        hit_err = (idx >= ERR_BASE);
        rd      = mem[idx];
        if (req.we && !hit_err) begin
          for (int l = 0; l < 4; l++) begin
            if (req.be[l]) mem[idx][8*l +: 8] = req.wdata[8*l +: 8];
          end
        end
        rv_wait = 1 + next_rand() % 3;
        @(posedge clk_i);
        data_gnt_i <= 1'b0;
        repeat (rv_wait - 1) @(posedge clk_i);
        data_rvalid_i <= 1'b1;
        data_err_i    <= hit_err;
        // Garbage read data where the response must carry zero
        data_rdata_i  <= (req.we || hit_err) ? next_rand() : rd;
        @(posedge clk_i);
        data_rvalid_i <= 1'b0;
        data_err_i    <= 1'b0;
        bus_count++;
      end
    end
  end

  // Response checker
  always @(negedge clk_i) begin
    if (rst_ni && resp_valid_o) begin
      resp_count++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Response at %0t with no accepted command waiting for it", $time);
      end else begin
        exp_resp = exp_q.pop_front();
        check_value("resp_o", resp_o, exp_resp);
      end
    end
  end

  // Watchdog
  initial begin
    #(NUM_CMDS * CYCLES_PER_CMD * CLK_PERIOD);
    $display("Timeout after %0d commands and %0d responses, errors %0d",
             cmd_count, resp_count, errors);
    $display(">>> FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    cmd_valid_i   = 1'b0;
    cmd_i         = '0;
    errors        = 0;
    cmd_count     = 0;
    resp_count    = 0;
    bus_count     = 0;
    ignored_count = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]    = next_rand();
      shadow[i] = mem[i];
    end
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("data_req_o", data_req_o, 1'b0);
    check_value("resp_valid_o", resp_valid_o, 1'b0);
    check_value("busy_o", busy_o, 1'b0);

    // Stores at every aligned offset, each read back signed and unsigned
    for (int off = 0; off < 4; off++) begin
      send_cmd(build_cmd(1'b1, lsu_pkg::SIZE_BYTE, 1'b0, 32'h10 + off, 32'h80 + off * 17));
      send_cmd(build_cmd(1'b0, lsu_pkg::SIZE_BYTE, 1'b1, 32'h10 + off, '0));
      send_cmd(build_cmd(1'b0, lsu_pkg::SIZE_BYTE, 1'b0, 32'h10 + off, '0));
    end
    for (int off = 0; off < 4; off += 2) begin
      send_cmd(build_cmd(1'b1, lsu_pkg::SIZE_HALF, 1'b0, 32'h14 + off, 32'h8001 + off * 32'h1111));
      send_cmd(build_cmd(1'b0, lsu_pkg::SIZE_HALF, 1'b1, 32'h14 + off, '0));
      send_cmd(build_cmd(1'b0, lsu_pkg::SIZE_HALF, 1'b0, 32'h14 + off, '0));
    end
    send_cmd(build_cmd(1'b1, lsu_pkg::SIZE_WORD, 1'b0, 32'h18, 32'ha5c3_1e7f));
    send_cmd(build_cmd(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h18, '0));

    // Misaligned, then the word read back to see it untouched
    for (int off = 1; off < 4; off++) begin
      send_cmd(build_cmd(1'b1, lsu_pkg::SIZE_WORD, 1'b0, 32'h20 + off, 32'hdead_beef));
      send_cmd(build_cmd(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h20 + off, '0));
      if (off % 2 == 1) begin
        send_cmd(build_cmd(1'b1, lsu_pkg::SIZE_HALF, 1'b0, 32'h20 + off, 32'h0000_cafe));
        send_cmd(build_cmd(1'b0, lsu_pkg::SIZE_HALF, 1'b1, 32'h20 + off, '0));
      end
    end
    send_cmd(build_cmd(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h20, '0));

    // Error region
    for (int idx = ERR_BASE; idx < MEM_WORDS; idx++) begin
      send_cmd(build_cmd(1'b1, lsu_pkg::SIZE_WORD, 1'b0, idx * 4, 32'h1234_5678));
      send_cmd(build_cmd(1'b0, lsu_pkg::SIZE_WORD, 1'b0, idx * 4, '0));
    end

    repeat (NUM_RANDOM) send_cmd(random_cmd());

    while (exp_q.size() != 0) @(negedge clk_i);
    repeat (4) @(negedge clk_i);

    check_value("response count", resp_count, cmd_count);
    check_value("pending bus requests", exp_bus_q.size(), 0);
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_value("memory word", mem[i], shadow[i]);
    end

    $display("Commands %0d, responses %0d, bus accesses %0d, ignored strobes %0d, errors %0d",
             cmd_count, resp_count, bus_count, ignored_count, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
logic/lsu_pkg.sv
logic/lsu_align.sv
logic/lsu_load_extract.sv
logic/lsu_bus_fsm.sv
logic/lsu_top.sv
bench/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

export_include_dirs:
  - .

sources:
  - logic/lsu_pkg.sv
  - logic/lsu_align.sv
  - logic/lsu_load_extract.sv
  - logic/lsu_bus_fsm.sv
  - logic/lsu_top.sv
  - target: test
    files:
      - bench/lsu_tb.sv
